//--- Bender.yml
package:
  name: serializer

sources:
  # Design sources, package first.
  - hdl/serdesPkg.sv
  - hdl/parInput.sv
  - hdl/txFifo.sv
  - hdl/serEncoder.sv
  - hdl/serializer.sv

  # Simulation only.
  - target: simulation
    files:
      - sim/serializer_assertions.sv
      - sim/serializerTb.sv

//--- build.f
hdl/serdesPkg.sv
hdl/parInput.sv
hdl/txFifo.sv
hdl/serEncoder.sv
hdl/serializer.sv
sim/serializer_assertions.sv
sim/serializerTb.sv

//--- hdl/parInput.sv
// Four-phase req/ack receiver that writes each accepted producer word into the transmit FIFO.
`timescale 1ns/1ps
`default_nettype none

module parInput (
  input  wire                             ParInClk,
  input  wire                             rstN,
  input  wire                             parReq,
  input  wire  [serdesPkg::DataWidth-1:0] parIn,
  output logic                            parAck,
  input  wire                             fifoFull,
  output logic                            fifoWrite,
  output logic [serdesPkg::DataWidth-1:0] fifoDin
);

  // New request seen while idle and the FIFO has room.
  logic accept;

  // parAck is held high, so a held request cannot write twice.
  assign accept = parReq && !parAck && !fifoFull;

  // --------------------------------------------------
  // Handshake FSM.
  // --------------------------------------------------

  // Two states carried by parAck itself.
  // Low means waiting for a request, high means acknowledged.
  always_ff @(posedge ParInClk or negedge rstN) begin
    if (!rstN) begin
      parAck    <= 1'b0;
      fifoWrite <= 1'b0;
    end else begin
      // One write pulse per accepted request.
      fifoWrite <= accept;
      if (accept) begin
        parAck <= 1'b1;
      end else if (!parReq) begin
        // Release once the producer drops its request.
        parAck <= 1'b0;
      end
    end
  end

  // Word is captured with the request, parIn is stable then.
  always_ff @(posedge ParInClk) begin
    if (accept) begin
      fifoDin <= parIn;
    end
  end

endmodule

`default_nettype wire

//--- hdl/serEncoder.sv
// Serial frame encoder that pops FIFO words and shifts out preamble, data and parity at half rate.
`timescale 1ns/1ps
`default_nettype none

module serEncoder (
  input  wire                            ParInClk,
  input  wire                            rstN,
  input  wire                            SendSerial,
  input  wire                            fifoEmpty,
  output logic                           fifoRead,
  input  wire [serdesPkg::DataWidth-1:0] fifoDout,
  output logic                           SerOut,
  output logic                           SerValid,
  output logic                           SerClk
);

  // FSM state.
  serdesPkg::EncStateT state;

  // Low in the first cycle of a bit period, high in the second.
  logic phase;

  // Bits still to send after the one on SerOut.
  logic [serdesPkg::BitCountWidth-1:0] bitCount;

  // Frame bits not yet on the line.
  logic [serdesPkg::FrameLen-2:0] shiftReg;

  // Complete frame built from the FIFO output.
  logic [serdesPkg::FrameLen-1:0] frame;

  // Frame control strobes.
  logic lastBit;
  logic loadFrame;
  logic nextBit;

  // --------------------------------------------------
  // Frame build and strobes.
  // --------------------------------------------------

  // Parity on top, data in the middle, preamble 01 at the LSB end so a one goes out first.
  assign frame = {^fifoDout, fifoDout, serdesPkg::PreambleLen'(1)};

  // Parity bit is on the line.
  assign lastBit = (state == serdesPkg::shift) && (bitCount == '0);

  // Pop when idle, or in the first half of the parity bit for back to back frames.
  assign fifoRead = SendSerial && !fifoEmpty &&
                    ((state == serdesPkg::idle) || (lastBit && !phase));

  // Bit boundaries fall on the edge that ends the high phase.
  assign loadFrame = (state == serdesPkg::load) && phase;
  assign nextBit   = (state == serdesPkg::shift) && phase && (bitCount != '0);

  // Bit clock rises mid-bit.
  assign SerClk = phase;

  // --------------------------------------------------
  // Control FSM.
  // --------------------------------------------------

  always_ff @(posedge ParInClk or negedge rstN) begin
    if (!rstN) begin
      phase    <= 1'b0;
      state    <= serdesPkg::idle;
      bitCount <= '0;
      SerOut   <= 1'b0;
      SerValid <= 1'b0;
    end else begin
      // Free-running half-rate toggle.
      phase <= !phase;
      case (state)
        serdesPkg::idle: begin
          if (fifoRead) begin
            state <= serdesPkg::load;
          end
        end
        serdesPkg::load: begin
          // fifoDout now holds the word, start at the boundary.
          if (loadFrame) begin
            state    <= serdesPkg::shift;
            bitCount <= serdesPkg::BitCountWidth'(serdesPkg::FrameLen - 1);
            SerOut   <= frame[0];
            SerValid <= 1'b1;
          end
        end
        serdesPkg::shift: begin
          if (fifoRead) begin
            // Next word popped during parity, SerValid stays high.
            state <= serdesPkg::load;
          end else if (nextBit) begin
            bitCount <= bitCount - 1'b1;
            SerOut   <= shiftReg[0];
          end else if (lastBit && phase) begin
            // Frame ends, nothing queued or sending paused.
            state    <= serdesPkg::idle;
            SerOut   <= 1'b0;
            SerValid <= 1'b0;
          end
        end
        default: begin
          state <= serdesPkg::idle;
        end
      endcase
    end
  end

  // Shift register, LSB goes to SerOut next.
  always_ff @(posedge ParInClk) begin
    if (loadFrame) begin
      shiftReg <= frame[serdesPkg::FrameLen-1:1];
    end else if (nextBit) begin
      shiftReg <= shiftReg >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/serdesPkg.sv
// Shared widths, FIFO sizing, frame layout and encoder states for the serializer RTL and testbench.
`default_nettype none

package serdesPkg;

  // --------------------------------------------------
  // Parallel side.
  // --------------------------------------------------

  // Width of one word from the producer.
  localparam int DataWidth = 32;

  // FIFO addressing; depth is a power of two.
  localparam int FifoAddrWidth = 5;
  localparam int FifoDepth = 1 << FifoAddrWidth;

  // --------------------------------------------------
  // Serial frame.
  // --------------------------------------------------

  // Preamble is a one then a zero, sent first.
  localparam int PreambleLen = 2;

  // Preamble, data LSB first, then one even parity bit.
  localparam int FrameLen = PreambleLen + DataWidth + 1;

  // Bit counter must hold FrameLen - 1.
  localparam int BitCountWidth = $clog2(FrameLen + 1);

  // Encoder FSM states.
  typedef enum logic [1:0] {idle, load, shift} EncStateT;

endpackage

`default_nettype wire

//--- hdl/serializer.sv
// Top level of the SerDes transmit half, wiring the handshake receiver, FIFO and serial encoder.
`timescale 1ns/1ps
`default_nettype none

module serializer (
  input  wire                            ParInClk,
  input  wire                            rstN,
  input  wire                            parReq,
  input  wire [serdesPkg::DataWidth-1:0] parIn,
  output wire                            parAck,
  input  wire                            SendSerial,
  output wire                            SerOut,
  output wire                            SerValid,
  output wire                            SerClk,
  output wire                            FIFOEmpty,
  output wire                            FIFOFull
);

  // --------------------------------------------------
  // Internal nets.
  // --------------------------------------------------

  // Receiver to FIFO.
  wire                            fifoWrite;
  wire [serdesPkg::DataWidth-1:0] fifoDin;

  // FIFO to encoder.
  wire                            fifoRead;
  wire [serdesPkg::DataWidth-1:0] fifoDout;

  // Status flags, also brought out.
  wire fifoFull;
  wire fifoEmpty;

  assign FIFOFull  = fifoFull;
  assign FIFOEmpty = fifoEmpty;

  // --------------------------------------------------
  // Structure.
  // --------------------------------------------------

  // Producer handshake.
  parInput parInTx1 (
    .ParInClk  (ParInClk),
    .rstN      (rstN),
    .parReq    (parReq),
    .parIn     (parIn),
    .parAck    (parAck),
    .fifoFull  (fifoFull),
    .fifoWrite (fifoWrite),
    .fifoDin   (fifoDin)
  );

  // Word queue, single clock.
  txFifo fifoTx1 (
    .ParInClk  (ParInClk),
    .rstN      (rstN),
    .fifoWrite (fifoWrite),
    .fifoDin   (fifoDin),
    .fifoRead  (fifoRead),
    .fifoDout  (fifoDout),
    .fifoFull  (fifoFull),
    .fifoEmpty (fifoEmpty)
  );

  // Frame encoder and bit clock.
  serEncoder serEncTx1 (
    .ParInClk   (ParInClk),
    .rstN       (rstN),
    .SendSerial (SendSerial),
    .fifoEmpty  (fifoEmpty),
    .fifoRead   (fifoRead),
    .fifoDout   (fifoDout),
    .SerOut     (SerOut),
    .SerValid   (SerValid),
    .SerClk     (SerClk)
  );

endmodule

`default_nettype wire

//--- hdl/txFifo.sv
// Synchronous word FIFO between the parallel receiver and the serial encoder, with full and empty flags.
`timescale 1ns/1ps
`default_nettype none

module txFifo (
  input  wire                             ParInClk,
  input  wire                             rstN,
  input  wire                             fifoWrite,
  input  wire  [serdesPkg::DataWidth-1:0] fifoDin,
  input  wire                             fifoRead,
  output logic [serdesPkg::DataWidth-1:0] fifoDout,
  output logic                            fifoFull,
  output logic                            fifoEmpty
);

  // Storage array.
  logic [serdesPkg::DataWidth-1:0] mem [serdesPkg::FifoDepth];

  // Pointers carry one extra wrap bit above the address.
  logic [serdesPkg::FifoAddrWidth:0] wrPtr;
  logic [serdesPkg::FifoAddrWidth:0] rdPtr;

  // Qualified requests.
  logic doWrite;
  logic doRead;

  // --------------------------------------------------
  // Flags.
  // --------------------------------------------------

  // Same address and same wrap means nothing stored.
  assign fifoEmpty = (wrPtr == rdPtr);

  // Same address but opposite wrap means every slot used.
  assign fifoFull = (wrPtr[serdesPkg::FifoAddrWidth] != rdPtr[serdesPkg::FifoAddrWidth]) &&
                    (wrPtr[serdesPkg::FifoAddrWidth-1:0] == rdPtr[serdesPkg::FifoAddrWidth-1:0]);

  // Overflow and underflow requests are dropped.
  assign doWrite = fifoWrite && !fifoFull;
  assign doRead  = fifoRead && !fifoEmpty;

  // --------------------------------------------------
  // Pointers.
  // --------------------------------------------------

  always_ff @(posedge ParInClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // Write side.
  always_ff @(posedge ParInClk) begin
    if (doWrite) begin
      mem[wrPtr[serdesPkg::FifoAddrWidth-1:0]] <= fifoDin;
    end
  end

  // Registered read, data valid the cycle after fifoRead.
  always_ff @(posedge ParInClk) begin
    if (doRead) begin
      fifoDout <= mem[rdPtr[serdesPkg::FifoAddrWidth-1:0]];
    end
  end

endmodule

`default_nettype wire

//--- sim/serializerTb.sv
// Testbench for the serializer top level; run it with the sources in build.f from the project root.
`timescale 1ns/1ps
`default_nettype none

module serializerTb;

  // Entries in the data file, three columns each.
  localparam int NumEntries = 20;
  // Cycles the held request must stay unanswered.
  localparam int HoldCycles = 100;
  // Bit index at which SendSerial is dropped.
  localparam int MidBit = 17;
  localparam int TailCycles = 100;
  localparam int CycleLimit = NumEntries * 80 + 3000;

  logic                            ParInClk;
  logic                            rstN;
  logic                            parReq;
  logic [serdesPkg::DataWidth-1:0] parIn;
  logic                            SendSerial;
  wire                             parAck;
  wire                             SerOut;
  wire                             SerValid;
  wire                             SerClk;
  wire                             FIFOEmpty;
  wire                             FIFOFull;

  // Data word, parity and pause flag per entry.
  logic [31:0] testMem [NumEntries*3];

  // Pending words as {parity, data}, oldest first.
  logic [serdesPkg::DataWidth:0]  expectQ [$];
  logic [serdesPkg::FrameLen-1:0] frameBits;
  int bitIdx = 0;
  int frameStarts = 0;
  int rxCount = 0;
  int acceptedCount = 0;
  int sendLowCycles = 0;
  int cycleCount = 0;
  int i;

  serializer serializer_inst (
    .ParInClk   (ParInClk),
    .rstN       (rstN),
    .parReq     (parReq),
    .parIn      (parIn),
    .parAck     (parAck),
    .SendSerial (SendSerial),
    .SerOut     (SerOut),
    .SerValid   (SerValid),
    .SerClk     (SerClk),
    .FIFOEmpty  (FIFOEmpty),
    .FIFOFull   (FIFOFull)
  );

  bind serializer serializerAssertions assertInst (
    .ParInClk  (ParInClk),
    .rstN      (rstN),
    .parReq    (parReq),
    .parAck    (parAck),
    .SerOut    (SerOut),
    .SerClk    (SerClk),
    .fifoWrite (fifoWrite),
    .fifoFull  (fifoFull)
  );

  always #10 ParInClk = !ParInClk;

  // --------------------------------------------------
  // Reporting and data access.
  // --------------------------------------------------

  task automatic stopRun();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic reportMismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("error at %0d ns: %s expected %0h actual %0h", $time, name, expected, actual);
    stopRun();
  endtask

  task automatic reportProblem(input string what);
    $display("at %0d ns: %s", $time, what);
    stopRun();
  endtask

  function automatic logic [31:0] wordOf(input int idx);
    return testMem[3*idx];
  endfunction

  function automatic logic parityOf(input int idx);
    return testMem[3*idx+1][0];
  endfunction

  function automatic logic pauseOf(input int idx);
    return testMem[3*idx+2][0];
  endfunction

  // --------------------------------------------------
  // Producer side.
  // --------------------------------------------------

  task automatic raiseRequest(input int idx);
    parIn  = wordOf(idx);
    parReq = 1'b1;
  endtask

  // Wait for the acknowledge, queue the word, then release.
  task automatic completeHandshake(input int idx);
    while (!parAck) @(negedge ParInClk);
    expectQ.push_back({parityOf(idx), wordOf(idx)});
    acceptedCount++;
    parReq = 1'b0;
    while (parAck) @(negedge ParInClk);
  endtask

  task automatic sendWord(input int idx);
    raiseRequest(idx);
    completeHandshake(idx);
  endtask

  // Pause mid-frame, fill the FIFO, then hold one more request.
  task automatic fillAndHold(input int idx);
    int fillIdx;
    int fillCount;
    int occupancy;
    int startsBefore;
    if (SerValid || !FIFOEmpty) begin
      while (!(SerValid && bitIdx == MidBit)) @(negedge ParInClk);
    end
    SendSerial = 1'b0;
    // Let a frame popped just before the drop get going.
    repeat (4) @(negedge ParInClk);
    fillIdx = idx;
    fillCount = 0;
    while (!FIFOFull) begin
      assert (fillCount < serdesPkg::FifoDepth)
        else reportProblem("FIFOFull did not rise after a full FIFO's worth of words");
      fillIdx = (fillIdx + 1) % NumEntries;
      sendWord(fillIdx);
      fillCount++;
      occupancy = acceptedCount - frameStarts;
      assert (FIFOFull == (occupancy == serdesPkg::FifoDepth))
        else reportMismatch("FIFOFull", occupancy == serdesPkg::FifoDepth, FIFOFull);
    end
    raiseRequest(idx);
    repeat (HoldCycles) begin
      @(negedge ParInClk);
      assert (!parAck) else reportProblem("request acknowledged while the FIFO was full");
    end
    startsBefore = frameStarts;
    SendSerial = 1'b1;
    completeHandshake(idx);
    repeat (2) @(negedge ParInClk);
    assert (frameStarts > startsBefore)
      else reportProblem("held request acknowledged but no frame started");
  endtask

  // --------------------------------------------------
  // Serial side.
  // --------------------------------------------------

  task automatic checkFrame(input logic [serdesPkg::FrameLen-1:0] bits);
    logic [serdesPkg::DataWidth:0] expected;
    assert (expectQ.size() > 0) else reportProblem("a frame arrived with no word pending");
    expected = expectQ.pop_front();
    assert (bits[1:0] == 2'b01) else reportMismatch("SerOut preamble", 2'b01, bits[1:0]);
    assert (bits[serdesPkg::FrameLen-2:2] == expected[serdesPkg::DataWidth-1:0])
      else reportMismatch("SerOut data", expected[serdesPkg::DataWidth-1:0],
                          bits[serdesPkg::FrameLen-2:2]);
    assert (bits[serdesPkg::FrameLen-1] == expected[serdesPkg::DataWidth])
      else reportMismatch("SerOut parity", expected[serdesPkg::DataWidth],
                          bits[serdesPkg::FrameLen-1]);
    rxCount++;
  endtask

  // SerOut is stable at the rising bit clock.
  always @(posedge SerClk) begin
    if (SerValid) begin
      if (bitIdx == 0) begin
        frameStarts++;
        assert (sendLowCycles <= 3) else reportProblem("a frame started while SendSerial was low");
      end
      frameBits[bitIdx] = SerOut;
      if (bitIdx == serdesPkg::FrameLen - 1) begin
        checkFrame(frameBits);
        bitIdx = 0;
      end else begin
        bitIdx++;
      end
    end else begin
      assert (bitIdx == 0) else reportProblem("SerValid fell before the frame was complete");
    end
  end

  // Cycle limit, and how long SendSerial has been low.
  always @(posedge ParInClk) begin
    cycleCount++;
    if (SendSerial) begin
      sendLowCycles = 0;
    end else begin
      sendLowCycles++;
    end
    if (cycleCount >= CycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", CycleLimit);
      stopRun();
    end
  end

  // --------------------------------------------------
  // Test sequence.
  // --------------------------------------------------

  initial begin
    ParInClk   = 1'b0;
    rstN       = 1'b0;
    parReq     = 1'b0;
    parIn      = '0;
    SendSerial = 1'b0;
    $readmemh("sim/serializer_testdata.txt", testMem);
    assert (!$isunknown(testMem[NumEntries*3-1]))
      else reportProblem("test data file is missing or short");
    repeat (8) @(negedge ParInClk);
    assert (SerClk == 1'b0) else reportMismatch("SerClk", 0, SerClk);
    assert (SerOut == 1'b0) else reportMismatch("SerOut", 0, SerOut);
    rstN = 1'b1;
    repeat (2) @(negedge ParInClk);
    // Idle state before any request.
    assert (parAck == 1'b0) else reportMismatch("parAck", 0, parAck);
    assert (SerValid == 1'b0) else reportMismatch("SerValid", 0, SerValid);
    assert (FIFOFull == 1'b0) else reportMismatch("FIFOFull", 0, FIFOFull);
    assert (FIFOEmpty == 1'b1) else reportMismatch("FIFOEmpty", 1, FIFOEmpty);
    SendSerial = 1'b1;
    for (i = 0; i < NumEntries; i++) begin
      if (pauseOf(i)) begin
        fillAndHold(i);
      end else begin
        sendWord(i);
      end
    end
    while (rxCount < acceptedCount) @(negedge ParInClk);
    // SerValid drops one cycle after the parity sample.
    repeat (2) @(negedge ParInClk);
    repeat (TailCycles) begin
      @(negedge ParInClk);
      assert (FIFOEmpty == 1'b1) else reportMismatch("FIFOEmpty", 1, FIFOEmpty);
      assert (SerValid == 1'b0) else reportMismatch("SerValid", 0, SerValid);
    end
    if (serializer_inst.assertInst.failCount == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("%0d concurrent assertion failures", serializer_inst.assertInst.failCount);
      stopRun();
    end
  end

endmodule

`default_nettype wire

//--- sim/serializer_assertions.sv
// Concurrent handshake, FIFO and serial line checks, bound into the serializer top level.
`timescale 1ns/1ps
`default_nettype none

module serializerAssertions (
  input wire ParInClk,
  input wire rstN,
  input wire parReq,
  input wire parAck,
  input wire SerOut,
  input wire SerClk,
  input wire fifoWrite,
  input wire fifoFull
);

  // Failures so far, read by the testbench at the end.
  int failCount = 0;

  // --------------------------------------------------
  // Handshake.
  // --------------------------------------------------

  // Acknowledge only answers a request.
  ackRise: assert property (@(posedge ParInClk) disable iff (!rstN)
    $rose(parAck) |-> $past(parReq))
    else begin
      $error("parAck rose while parReq was low");
      failCount++;
    end

  // Acknowledge is held until the request is released.
  ackFall: assert property (@(posedge ParInClk) disable iff (!rstN)
    $fell(parAck) |-> $past(!parReq))
    else begin
      $error("parAck fell while parReq was still high");
      failCount++;
    end

  // --------------------------------------------------
  // Line and FIFO.
  // --------------------------------------------------

  // Data changes only at the end of the high phase.
  serOutStable: assert property (@(posedge ParInClk) disable iff (!rstN)
    $rose(SerClk) |-> $stable(SerOut))
    else begin
      $error("SerOut changed while SerClk was high");
      failCount++;
    end

  // No overflow write.
  noFullWrite: assert property (@(posedge ParInClk) disable iff (!rstN)
    fifoWrite |-> !fifoFull)
    else begin
      $error("fifoWrite issued while fifoFull was high");
      failCount++;
    end

endmodule

`default_nettype wire

//--- sim/serializer_testdata.txt
// Columns: data word (hex), even parity of the word, SendSerial pause flag.
// A pause flag of 1 drops SendSerial mid-frame and fills the FIFO before this word.
00000000 0 0
FFFFFFFF 0 0
00000001 1 0
80000000 1 0
A5A5A5A5 0 0
12345678 1 0
DEADBEEF 0 0
0000FFFF 0 0
00000007 1 0
CAFEF00D 0 0
55555555 0 1
13579BDF 0 0
0F0F0F0E 1 0
7FFFFFFF 1 0
00010000 1 0
3C3C3C3C 0 0
01234567 0 0
89ABCDEF 0 0
0000000B 1 0
FEDCBA98 0 0
